// File: hdl/closurePkg.sv
package closurePkg;

    // seven-variable Boolean functions as truth tables
    localparam int VAR_COUNT = 7;
    localparam int VEC_WIDTH = 1 << VAR_COUNT;

    // the cube is split into 16-point blocks over the low four dimensions
    localparam int PART_WIDTH = 16;
    localparam int PART_COUNT = VEC_WIDTH / PART_WIDTH;

    // popcount must hold the value VEC_WIDTH itself
    localparam int COUNT_WIDTH = VAR_COUNT + 1;

    // sequence tag, wraps at 16
    localparam int TAG_WIDTH = 4;

    // which closure a request asks for
    typedef enum logic {
        OP_UP   = 1'b0,
        OP_DOWN = 1'b1
    } closureOp_e;

endpackage

// File: hdl/monotonizePart16.sv
`timescale 1ns/100ps

module monotonizePart16 import closurePkg::*; (
    input  logic                  clk,
    input  logic [PART_WIDTH-1:0] din,
    output logic [PART_WIDTH-1:0] dout
);

    // delayed input serves the weight-0 and weight-1 points
    logic [PART_WIDTH-1:0] dinD;

    // weight-2 points in order 0011, 0101, 0110, 1001, 1010, 1100
    logic [5:0] quad;
    logic [5:0] quadD;

    // weight-3 points in order 0111, 1011, 1101, 1110
    logic [3:0] oct;
    logic [3:0] octD;

    // top point 1111 sees the whole block
    logic cubeAny;
    logic cubeAnyD;

    // shared groups on the two high bits
    logic group01xx;
    logic group10xx;
    logic group11xx;

    assign group01xx = din[4'b0111] | din[4'b0110] | din[4'b0101] | din[4'b0100];
    assign group10xx = din[4'b1011] | din[4'b1010] | din[4'b1001] | din[4'b1000];
    assign group11xx = din[4'b1111] | din[4'b1110] | din[4'b1101] | din[4'b1100];

    // each weight-2 point ORs its four subsets
    assign quad[0] = din[4'b0011] | din[4'b0010] | din[4'b0001] | din[4'b0000];
    assign quad[1] = din[4'b0101] | din[4'b0100] | din[4'b0001] | din[4'b0000];
    assign quad[2] = din[4'b0110] | din[4'b0100] | din[4'b0010] | din[4'b0000];
    assign quad[3] = din[4'b1001] | din[4'b1000] | din[4'b0001] | din[4'b0000];
    assign quad[4] = din[4'b1010] | din[4'b1000] | din[4'b0010] | din[4'b0000];
    assign quad[5] = din[4'b1100] | din[4'b1000] | din[4'b0100] | din[4'b0000];

    // weight-3 points reuse a quad plus one more group of four
    assign oct[0] = quad[0] | group01xx;
    assign oct[1] = quad[0] | group10xx;
    assign oct[2] = quad[5] | (din[4'b1101] | din[4'b1001] | din[4'b0101] | din[4'b0001]);
    assign oct[3] = quad[5] | (din[4'b1110] | din[4'b1010] | din[4'b0110] | din[4'b0010]);

    assign cubeAny = quad[0] | group01xx | group10xx | group11xx;

    always_ff @(posedge clk) begin
        dinD     <= din;
        quadD    <= quad;
        octD     <= oct;
        cubeAnyD <= cubeAny;
    end

    assign dout[4'b1111] = cubeAnyD;

    assign dout[4'b0111] = octD[0];
    assign dout[4'b1011] = octD[1];
    assign dout[4'b1101] = octD[2];
    assign dout[4'b1110] = octD[3];

    assign dout[4'b0011] = quadD[0];
    assign dout[4'b0101] = quadD[1];
    assign dout[4'b0110] = quadD[2];
    assign dout[4'b1001] = quadD[3];
    assign dout[4'b1010] = quadD[4];
    assign dout[4'b1100] = quadD[5];

    // single-bit points only need the origin
    assign dout[4'b0001] = dinD[4'b0001] | dinD[4'b0000];
    assign dout[4'b0010] = dinD[4'b0010] | dinD[4'b0000];
    assign dout[4'b0100] = dinD[4'b0100] | dinD[4'b0000];
    assign dout[4'b1000] = dinD[4'b1000] | dinD[4'b0000];

    assign dout[4'b0000] = dinD[4'b0000];

endmodule

// File: hdl/pipelinedMonotonize.sv
`timescale 1ns/100ps

module pipelinedMonotonizeUp import closurePkg::*; (
    input  logic                 clk,
    input  logic [VEC_WIDTH-1:0] vIn,
    output logic [VEC_WIDTH-1:0] vOut
);

    // level 0 is the registered block output, levels 1..3 add dimensions 4..6
    wire [VEC_WIDTH-1:0] level [0:3];

    for (genvar b = 0; b < PART_COUNT; b++) begin : gBlock
        monotonizePart16 uPart (
            .clk  (clk),
            .din  (vIn[b*PART_WIDTH +: PART_WIDTH]),
            .dout (level[0][b*PART_WIDTH +: PART_WIDTH])
        );
    end

    for (genvar k = 0; k < 3; k++) begin : gLevel
        localparam int Stride = PART_WIDTH << k;
        for (genvar i = 0; i < VEC_WIDTH; i++) begin : gBit
            if ((i / Stride) % 2 == 1) begin : gOr
                // point with this dimension set inherits from its lower neighbour
                assign level[k+1][i] = level[k][i] | level[k][i-Stride];
            end else begin : gPass
                assign level[k+1][i] = level[k][i];
            end
        end
    end

    assign vOut = level[3];

endmodule


module pipelinedMonotonizeDown import closurePkg::*; (
    input  logic                 clk,
    input  logic [VEC_WIDTH-1:0] vIn,
    output logic [VEC_WIDTH-1:0] vOut
);

    // level 0 has the high dimensions closed, levels 1..3 close dimensions 2..0
    wire [VEC_WIDTH-1:0] level [0:3];

    for (genvar b = 0; b < PART_COUNT; b++) begin : gBlock
        wire [PART_WIDTH-1:0] gatherIn;
        wire [PART_WIDTH-1:0] gatherOut;

        // reversed order turns the upward block into a downward one
        for (genvar j = 0; j < PART_WIDTH; j++) begin : gGather
            assign gatherIn[PART_WIDTH-1-j]      = vIn[PART_COUNT*j + b];
            assign level[0][PART_COUNT*j + b] = gatherOut[PART_WIDTH-1-j];
        end

        monotonizePart16 uPart (
            .clk  (clk),
            .din  (gatherIn),
            .dout (gatherOut)
        );
    end

    for (genvar k = 0; k < 3; k++) begin : gLevel
        localparam int Stride = (PART_COUNT / 2) >> k;
        for (genvar i = 0; i < VEC_WIDTH; i++) begin : gBit
            if ((i / Stride) % 2 == 0) begin : gOr
                // point with this dimension clear inherits from its upper neighbour
                assign level[k+1][i] = level[k][i] | level[k][i+Stride];
            end else begin : gPass
                assign level[k+1][i] = level[k][i];
            end
        end
    end

    assign vOut = level[3];

endmodule

// File: hdl/closureIssue.sv
`timescale 1ns/100ps

module closureIssue import closurePkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 inStrobe,
    input  closureOp_e           inOp,
    input  logic [VEC_WIDTH-1:0] inVec,
    output logic                 issueStrobe,
    output closureOp_e           issueOp,
    output logic [VEC_WIDTH-1:0] issueVec,
    output logic [TAG_WIDTH-1:0] issueTag
);

    // tag for the next accepted request
    logic [TAG_WIDTH-1:0] tagCount;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            issueStrobe <= 1'b0;
            tagCount    <= '0;
        end else begin
            issueStrobe <= inStrobe;
            if (inStrobe) begin
                tagCount <= tagCount + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (inStrobe) begin
            issueOp  <= inOp;
            issueVec <= inVec;
            issueTag <= tagCount;
        end
    end

endmodule

// File: hdl/closureCore.sv
`timescale 1ns/100ps

module closureCore import closurePkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 issueStrobe,
    input  closureOp_e           issueOp,
    input  logic [VEC_WIDTH-1:0] issueVec,
    input  logic [TAG_WIDTH-1:0] issueTag,
    output logic                 coreStrobe,
    output closureOp_e           coreOp,
    output logic [TAG_WIDTH-1:0] coreTag,
    output logic [VEC_WIDTH-1:0] coreVec,
    output logic [VEC_WIDTH-1:0] upVec,
    output logic [VEC_WIDTH-1:0] downVec
);

    // both closures run on every request, the result stage picks one
    pipelinedMonotonizeUp uUp (
        .clk  (clk),
        .vIn  (issueVec),
        .vOut (upVec)
    );

    pipelinedMonotonizeDown uDown (
        .clk  (clk),
        .vIn  (issueVec),
        .vOut (downVec)
    );

    // sideband follows the single block register stage
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            coreStrobe <= 1'b0;
        end else begin
            coreStrobe <= issueStrobe;
        end
    end

    always_ff @(posedge clk) begin
        coreOp  <= issueOp;
        coreTag <= issueTag;
        // original kept for the closed check
        coreVec <= issueVec;
    end

endmodule

// File: hdl/closureResult.sv
`timescale 1ns/100ps

module closureResult import closurePkg::*; (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   coreStrobe,
    input  closureOp_e             coreOp,
    input  logic [TAG_WIDTH-1:0]   coreTag,
    input  logic [VEC_WIDTH-1:0]   coreVec,
    input  logic [VEC_WIDTH-1:0]   upVec,
    input  logic [VEC_WIDTH-1:0]   downVec,
    output logic                   outStrobe,
    output logic [TAG_WIDTH-1:0]   outTag,
    output logic [VEC_WIDTH-1:0]   outVec,
    output logic                   outClosed,
    output logic [COUNT_WIDTH-1:0] outCount
);

    logic [VEC_WIDTH-1:0]   selVec;
    logic                   selClosed;
    logic [COUNT_WIDTH-1:0] selCount;

    assign selVec = (coreOp == OP_UP) ? upVec : downVec;

    // a closure only adds points, so equality means nothing was added
    assign selClosed = (selVec == coreVec);

    always_comb begin
        selCount = '0;
        for (int k = 0; k < VEC_WIDTH; k++) begin
            selCount = selCount + COUNT_WIDTH'(selVec[k]);
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            outStrobe <= 1'b0;
        end else begin
            outStrobe <= coreStrobe;
        end
    end

    always_ff @(posedge clk) begin
        if (coreStrobe) begin
            outTag    <= coreTag;
            outVec    <= selVec;
            outClosed <= selClosed;
            outCount  <= selCount;
        end
    end

endmodule

// File: hdl/closureUnit.sv
`timescale 1ns/100ps

module closureUnit import closurePkg::*; (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   inStrobe,
    input  closureOp_e             inOp,
    input  logic [VEC_WIDTH-1:0]   inVec,
    output logic                   outStrobe,
    output logic [TAG_WIDTH-1:0]   outTag,
    output logic [VEC_WIDTH-1:0]   outVec,
    output logic                   outClosed,
    output logic [COUNT_WIDTH-1:0] outCount
);

    // issue to core
    logic                 issueStrobe;
    closureOp_e           issueOp;
    logic [VEC_WIDTH-1:0] issueVec;
    logic [TAG_WIDTH-1:0] issueTag;

    // core to result
    logic                 coreStrobe;
    closureOp_e           coreOp;
    logic [TAG_WIDTH-1:0] coreTag;
    logic [VEC_WIDTH-1:0] coreVec;
    logic [VEC_WIDTH-1:0] upVec;
    logic [VEC_WIDTH-1:0] downVec;

    closureIssue uIssue (
        .clk         (clk),
        .rstN        (rstN),
        .inStrobe    (inStrobe),
        .inOp        (inOp),
        .inVec       (inVec),
        .issueStrobe (issueStrobe),
        .issueOp     (issueOp),
        .issueVec    (issueVec),
        .issueTag    (issueTag)
    );

    closureCore uCore (
        .clk         (clk),
        .rstN        (rstN),
        .issueStrobe (issueStrobe),
        .issueOp     (issueOp),
        .issueVec    (issueVec),
        .issueTag    (issueTag),
        .coreStrobe  (coreStrobe),
        .coreOp      (coreOp),
        .coreTag     (coreTag),
        .coreVec     (coreVec),
        .upVec       (upVec),
        .downVec     (downVec)
    );

    closureResult uResult (
        .clk        (clk),
        .rstN       (rstN),
        .coreStrobe (coreStrobe),
        .coreOp     (coreOp),
        .coreTag    (coreTag),
        .coreVec    (coreVec),
        .upVec      (upVec),
        .downVec    (downVec),
        .outStrobe  (outStrobe),
        .outTag     (outTag),
        .outVec     (outVec),
        .outClosed  (outClosed),
        .outCount   (outCount)
    );

endmodule

// File: verification/closureUnit_assertions.sv
`timescale 1ns/100ps

module closureUnit_assertions import closurePkg::*; (
    input logic                   clk,
    input logic                   rstN,
    input logic                   inStrobe,
    input logic                   outStrobe,
    input logic [COUNT_WIDTH-1:0] outCount
);

    // no result leaves while reset is held
    assert property (@(posedge clk) !rstN |-> !outStrobe)
        else $error("outStrobe high during reset");

    // three strobe registers from input to output
    assert property (@(posedge clk) disable iff (!rstN) outStrobe == $past(inStrobe, 3))
        else $error("outStrobe does not follow inStrobe by three cycles");

    assert property (@(posedge clk) disable iff (!rstN)
                     outStrobe |-> outCount <= COUNT_WIDTH'(VEC_WIDTH))
        else $error("outCount exceeds the vector width");

endmodule

bind closureUnit closureUnit_assertions uAssertions (
    .clk       (clk),
    .rstN      (rstN),
    .inStrobe  (inStrobe),
    .outStrobe (outStrobe),
    .outCount  (outCount)
);

// File: verification/closureUnitTb.sv
`timescale 1ns/100ps

module closureUnitTb import closurePkg::*; ();

    // a result is presented three cycles after its request
    localparam int Latency = 3;
    localparam int RandomCount = 40;
    localparam int RequestTotal = 2 * VEC_WIDTH + RandomCount + 12 + 4 + 14 + 7;
    localparam int CycleLimit = 20 * RequestTotal + 100;

    logic                   clk;
    logic                   rstN;
    logic                   inStrobe;
    closureOp_e             inOp;
    logic [VEC_WIDTH-1:0]   inVec;
    logic                   outStrobe;
    logic [TAG_WIDTH-1:0]   outTag;
    logic [VEC_WIDTH-1:0]   outVec;
    logic                   outClosed;
    logic [COUNT_WIDTH-1:0] outCount;

    int cycleCount = 0;
    int errorCount = 0;
    int checkCount = 0;
    logic [31:0] rngState = 32'd37735;
    logic [TAG_WIDTH-1:0] nextTag;

    // expected results in request order
    logic [VEC_WIDTH-1:0]   expVecQ[$];
    logic                   expClosedQ[$];
    logic [COUNT_WIDTH-1:0] expCountQ[$];
    logic [TAG_WIDTH-1:0]   expTagQ[$];
    int                     expCycleQ[$];

    closureUnit u_closureUnit (
        .clk       (clk),
        .rstN      (rstN),
        .inStrobe  (inStrobe),
        .inOp      (inOp),
        .inVec     (inVec),
        .outStrobe (outStrobe),
        .outTag    (outTag),
        .outVec    (outVec),
        .outClosed (outClosed),
        .outCount  (outCount)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CycleLimit) begin
            $display("run stopped after %0d cycles, the tests did not finish", cycleCount);
            $display("Test FAILED");
            $finish;
        end
    end

    // xorshift32 step on the shared state
    function automatic logic [31:0] nextRandom();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    function automatic logic [VEC_WIDTH-1:0] randomVec();
        return {nextRandom(), nextRandom(), nextRandom(), nextRandom()};
    endfunction

    function automatic closureOp_e randomOp();
        logic [31:0] r;
        r = nextRandom();
        return r[0] ? OP_DOWN : OP_UP;
    endfunction

    // sparse vector so the closures stay varied
    function automatic logic [VEC_WIDTH-1:0] twoPointVec();
        logic [VEC_WIDTH-1:0] v;
        logic [31:0] r;
        v = '0;
        r = nextRandom();
        v[r[VAR_COUNT-1:0]] = 1'b1;
        r = nextRandom();
        v[r[VAR_COUNT-1:0]] = 1'b1;
        return v;
    endfunction

    function automatic int bitWeight(input int j);
        int w;
        w = 0;
        for (int b = 0; b < VAR_COUNT; b++) begin
            w = w + ((j >> b) & 1);
        end
        return w;
    endfunction

    // upward means j's bits lie within i's and downward the reverse
    function automatic logic [VEC_WIDTH-1:0] refClosure(input closureOp_e op,
                                                        input logic [VEC_WIDTH-1:0] v);
        logic [VEC_WIDTH-1:0] r;
        logic covered;
        r = '0;
        for (int i = 0; i < VEC_WIDTH; i++) begin
            for (int j = 0; j < VEC_WIDTH; j++) begin
                covered = (op == OP_UP) ? ((j & ~i) == 0) : ((i & ~j) == 0);
                if (covered && v[j]) begin
                    r[i] = 1'b1;
                end
            end
        end
        return r;
    endfunction

    function automatic logic [COUNT_WIDTH-1:0] refCount(input logic [VEC_WIDTH-1:0] v);
        return COUNT_WIDTH'($countones(v));
    endfunction

    task automatic checkValue(input logic [VEC_WIDTH-1:0] actual,
                              input logic [VEC_WIDTH-1:0] expected, input string what);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("Fail at %0t: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic sendChecked(input closureOp_e op, input logic [VEC_WIDTH-1:0] vec,
                               input logic [VEC_WIDTH-1:0] expVec, input logic expClosed,
                               input logic [COUNT_WIDTH-1:0] expCount);
        @(posedge clk);
        #0.5;
        inStrobe = 1'b1;
        inOp = op;
        inVec = vec;
        expVecQ.push_back(expVec);
        expClosedQ.push_back(expClosed);
        expCountQ.push_back(expCount);
        expTagQ.push_back(nextTag);
        expCycleQ.push_back(cycleCount);
        nextTag = TAG_WIDTH'(nextTag + 1);
    endtask

    task automatic sendRequest(input closureOp_e op, input logic [VEC_WIDTH-1:0] vec);
        logic [VEC_WIDTH-1:0] expVec;
        expVec = refClosure(op, vec);
        sendChecked(op, vec, expVec, expVec == vec, refCount(expVec));
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #0.5;
            inStrobe = 1'b0;
        end
    endtask

    task automatic clearExpected();
        expVecQ.delete();
        expClosedQ.delete();
        expCountQ.delete();
        expTagQ.delete();
        expCycleQ.delete();
    endtask

    // wait for outstanding results and report any still missing
    task automatic drain();
        int waited;
        idle(1);
        waited = 0;
        while (expVecQ.size() != 0 && waited < 2 * Latency + 4) begin
            @(negedge clk);
            waited++;
        end
        if (expVecQ.size() != 0) begin
            errorCount += expVecQ.size();
            $display("%0d results never arrived, first missing tag %0d",
                     expVecQ.size(), expTagQ[0]);
            clearExpected();
        end
    endtask

    always @(negedge clk) begin : resultMonitor
        int latency;
        if (outStrobe) begin
            if (expVecQ.size() == 0) begin
                errorCount++;
                $display("unexpected result with tag %0d at %0t", outTag, $time);
            end else begin
                latency = cycleCount - expCycleQ.pop_front();
                checkValue(outVec, expVecQ.pop_front(), "outVec");
                checkValue(VEC_WIDTH'(outClosed), VEC_WIDTH'(expClosedQ.pop_front()), "outClosed");
                checkValue(VEC_WIDTH'(outCount), VEC_WIDTH'(expCountQ.pop_front()), "outCount");
                checkValue(VEC_WIDTH'(outTag), VEC_WIDTH'(expTagQ.pop_front()), "outTag");
                checkValue(VEC_WIDTH'(latency), VEC_WIDTH'(Latency), "latency");
            end
        end
    end

    task automatic testSinglePoints();
        logic [VEC_WIDTH-1:0] vec;
        int w;
        for (int j = 0; j < VEC_WIDTH; j++) begin
            vec = '0;
            vec[j] = 1'b1;
            w = bitWeight(j);
            // supersets span the clear bits and subsets the set bits
            sendChecked(OP_UP, vec, refClosure(OP_UP, vec), j == VEC_WIDTH - 1,
                        COUNT_WIDTH'(1 << (VAR_COUNT - w)));
            sendChecked(OP_DOWN, vec, refClosure(OP_DOWN, vec), j == 0,
                        COUNT_WIDTH'(1 << w));
        end
        drain();
    endtask

    task automatic testRandomVectors();
        logic [31:0] r;
        for (int k = 0; k < RandomCount; k++) begin
            sendRequest(randomOp(), randomVec());
            r = nextRandom();
            if (r[1]) begin
                idle(1);
            end
        end
        drain();
    endtask

    task automatic testClosedInputs();
        closureOp_e op;
        logic [VEC_WIDTH-1:0] vec;
        logic [VEC_WIDTH-1:0] expVec;
        for (int k = 0; k < 8; k++) begin
            op = (k % 2 == 0) ? OP_UP : OP_DOWN;
            expVec = refClosure(op, twoPointVec());
            sendChecked(op, expVec, expVec, 1'b1, refCount(expVec));
        end
        for (int k = 0; k < 4; k++) begin
            op = (k % 2 == 0) ? OP_DOWN : OP_UP;
            vec = twoPointVec();
            expVec = refClosure(op, vec);
            while (expVec == vec) begin
                vec = twoPointVec();
                expVec = refClosure(op, vec);
            end
            sendChecked(op, vec, expVec, 1'b0, refCount(expVec));
        end
        drain();
    endtask

    task automatic testEdgeVectors();
        sendChecked(OP_UP, '0, '0, 1'b1, '0);
        sendChecked(OP_DOWN, '0, '0, 1'b1, '0);
        sendChecked(OP_UP, '1, '1, 1'b1, COUNT_WIDTH'(VEC_WIDTH));
        sendChecked(OP_DOWN, '1, '1, 1'b1, COUNT_WIDTH'(VEC_WIDTH));
        drain();
    endtask

    // bursts of 2 to 5 requests with growing gaps
    task automatic testBackToBack();
        for (int b = 1; b <= 4; b++) begin
            repeat (b + 1) sendRequest(randomOp(), randomVec());
            idle(b);
        end
        drain();
    endtask

    task automatic testResetMidStream();
        repeat (4) sendRequest(randomOp(), randomVec());
        @(posedge clk);
        #0.5;
        rstN = 1'b0;
        inStrobe = 1'b0;
        // in-flight requests are dropped and the tag restarts
        clearExpected();
        nextTag = '0;
        repeat (4) @(posedge clk);
        #0.5;
        rstN = 1'b1;
        idle(10);
        repeat (3) sendRequest(randomOp(), randomVec());
        drain();
    endtask

    initial begin
        rstN = 1'b0;
        inStrobe = 1'b0;
        inOp = OP_UP;
        inVec = '0;
        nextTag = '0;
        repeat (5) @(posedge clk);
        #0.5;
        rstN = 1'b1;
        testSinglePoints();
        testRandomVectors();
        testClosedInputs();
        testEdgeVectors();
        testBackToBack();
        testResetMidStream();
        $display("checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: tb.f
hdl/closurePkg.sv
hdl/monotonizePart16.sv
hdl/pipelinedMonotonize.sv
hdl/closureIssue.sv
hdl/closureCore.sv
hdl/closureResult.sv
hdl/closureUnit.sv
verification/closureUnit_assertions.sv
verification/closureUnitTb.sv

// File: run.sh
#!/bin/sh
# build and run the closure unit testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module closureUnitTb \
    -f tb.f -o closureSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/closureSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Test OK" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
